/* src/fpslice_pkg.sv */
// Formats FP32/FP16 only, tags fixed at TAG_WIDTH bits, only the NV flag is ever raised
package fpslice_pkg;

  // ----------------------------------------
  // Formats and operations
  // ----------------------------------------
  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_fmt_e;

  typedef enum logic {
    OP_MIN = 1'b0,
    OP_MAX = 1'b1
  } fp_op_e;

  // IEEE 754 exception flags, same order as the RISC-V fflags CSR
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  // ----------------------------------------
  // Slice configuration
  // ----------------------------------------
  // FP16 lanes that fit in one 32-bit word
  localparam int unsigned NUM_LANES             = 2;
  localparam int unsigned NUM_PIPE_REGS_DEFAULT = 2;
  localparam int unsigned TAG_WIDTH             = 8;

  typedef logic [TAG_WIDTH-1:0] tag_t;

  // Canonical quiet NaNs
  localparam logic [31:0] FP32_CANON_NAN = 32'h7fc0_0000;
  localparam logic [15:0] FP16_CANON_NAN = 16'h7e00;

  // ----------------------------------------
  // Lane payloads
  // ----------------------------------------
  // An FP16 lane only looks at the low 16 bits of each operand
  typedef struct packed {
    logic [31:0] op_a;
    logic [31:0] op_b;
    fp_op_e      op;
    fp_fmt_e     fmt;
    logic        vector;
    tag_t        tag;
  } lane_req_t;

  // Result is right-aligned within the word
  typedef struct packed {
    logic [31:0] result;
    status_t     status;
    fp_fmt_e     fmt;
    logic        vector;
    tag_t        tag;
  } lane_rsp_t;

endpackage

/* src/fp_pipe_regs.sv */
// NumPipeRegs of 0 gives a purely combinational path; data registers carry no reset
`timescale 1ns/1ps

module fp_pipe_regs #(
  parameter int unsigned NumPipeRegs = 1,
  parameter type         payload_t   = logic
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o,
  input  logic     flush_i,
  output logic     busy_o
);

  // Index i holds the item after i register stages
  payload_t             stage_data [NumPipeRegs+1];
  logic [0:NumPipeRegs] stage_valid;
  logic [0:NumPipeRegs] stage_ready;

  assign stage_data[0]  = in_data_i;
  assign stage_valid[0] = in_valid_i;
  assign in_ready_o     = stage_ready[0];

  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stage
    logic reg_en;

    // Advance when the next stage moves on or only holds a bubble
    assign stage_ready[i] = stage_ready[i+1] | ~stage_valid[i+1];
    assign reg_en         = stage_ready[i] & stage_valid[i];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        stage_valid[i+1] <= 1'b0;
      end else if (flush_i) begin
        stage_valid[i+1] <= 1'b0;
      end else if (stage_ready[i]) begin
        stage_valid[i+1] <= stage_valid[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (reg_en) begin
        stage_data[i+1] <= stage_data[i];
      end
    end
  end

  // Ready enters from the downstream side
  assign stage_ready[NumPipeRegs] = out_ready_i;
  assign out_valid_o              = stage_valid[NumPipeRegs];
  assign out_data_o               = stage_data[NumPipeRegs];

  if (NumPipeRegs > 0) begin : gen_busy_regs
    assign busy_o = |stage_valid[1:NumPipeRegs];

    // A stalled item must not change under the consumer
    a_stall_stable : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (out_valid_o && !out_ready_i) |=> $stable(out_data_o));
  end else begin : gen_busy_comb
    assign busy_o = in_valid_i;
  end

endmodule

/* src/fp_minmax_lane.sv */
// RISC-V min/max semantics; FP16 uses operand bits 15:0 and the upper bits are not NaN-box checked
`timescale 1ns/1ps

module fp_minmax_lane #(
  parameter int unsigned NumPipeRegs = fpslice_pkg::NUM_PIPE_REGS_DEFAULT
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  fpslice_pkg::lane_req_t req_i,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  output fpslice_pkg::lane_rsp_t rsp_o,
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  input  logic                   flush_i,
  output logic                   busy_o
);

  import fpslice_pkg::*;

  // Per-operand classification, magnitude excludes the sign
  typedef struct packed {
    logic        is_nan;
    logic        is_snan;
    logic        sign;
    logic [30:0] mag;
  } operand_info_t;

  function automatic operand_info_t classify(input logic [31:0] val, input fp_fmt_e fmt);
    operand_info_t info;
    info = '0;
    if (fmt == FP32) begin
      info.is_nan  = (val[30:23] == 8'hff) && (val[22:0] != '0);
      // Quiet bit is the MSB of the mantissa
      info.is_snan = info.is_nan && !val[22];
      info.sign    = val[31];
      info.mag     = val[30:0];
    end else begin
      info.is_nan  = (val[14:10] == 5'h1f) && (val[9:0] != '0);
      info.is_snan = info.is_nan && !val[9];
      info.sign    = val[15];
      info.mag     = {16'h0, val[14:0]};
    end
    return info;
  endfunction

  logic [31:0]   a_val;
  logic [31:0]   b_val;
  operand_info_t a_info;
  operand_info_t b_info;
  logic          a_lt_b;
  lane_rsp_t     rsp_d;

  // ----------------------------------------
  // Operand alignment and classification
  // ----------------------------------------
  always_comb begin : operand_align
    if (req_i.fmt == FP32) begin
      a_val = req_i.op_a;
      b_val = req_i.op_b;
    end else begin
      a_val = {16'h0, req_i.op_a[15:0]};
      b_val = {16'h0, req_i.op_b[15:0]};
    end
  end

  assign a_info = classify(a_val, req_i.fmt);
  assign b_info = classify(b_val, req_i.fmt);

  // Sign-magnitude ordering, so -0 sorts below +0
  always_comb begin : order
    if (a_info.sign != b_info.sign) begin
      a_lt_b = a_info.sign;
    end else if (a_info.sign) begin
      a_lt_b = a_info.mag > b_info.mag;
    end else begin
      a_lt_b = a_info.mag < b_info.mag;
    end
  end

  // ----------------------------------------
  // Result selection
  // ----------------------------------------
  always_comb begin : select
    rsp_d           = '0;
    rsp_d.fmt       = req_i.fmt;
    rsp_d.vector    = req_i.vector;
    rsp_d.tag       = req_i.tag;
    rsp_d.status.nv = a_info.is_snan | b_info.is_snan;
    if (a_info.is_nan && b_info.is_nan) begin
      rsp_d.result = (req_i.fmt == FP32) ? FP32_CANON_NAN : {16'h0, FP16_CANON_NAN};
    end else if (a_info.is_nan) begin
      rsp_d.result = b_val;
    end else if (b_info.is_nan) begin
      rsp_d.result = a_val;
    end else if (req_i.op == OP_MIN) begin
      rsp_d.result = a_lt_b ? a_val : b_val;
    end else begin
      rsp_d.result = a_lt_b ? b_val : a_val;
    end
  end

  // Output registers
  fp_pipe_regs #(
    .NumPipeRegs ( NumPipeRegs ),
    .payload_t   ( lane_rsp_t  )
  ) u_fp_pipe_regs (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .in_data_i   ( rsp_d       ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .out_data_o  ( rsp_o       ),
    .flush_i     ( flush_i     ),
    .busy_o      ( busy_o      )
  );

  // The slice only marks FP16 operations as vectors
  a_vector_fp16 : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (in_valid_i && req_i.vector) |-> (req_i.fmt == FP16));

endmodule

/* src/fp_minmax_slice.sv */
// Scalar FP16 results are NaN-boxed; lane 1 exists only with EnableVectors; tags are 8 bits
`timescale 1ns/1ps

module fp_minmax_slice #(
  parameter int unsigned NumPipeRegs   = fpslice_pkg::NUM_PIPE_REGS_DEFAULT,
  parameter logic        EnableVectors = 1'b1
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  // Request
  input  logic [31:0]          op_a_i,
  input  logic [31:0]          op_b_i,
  input  fpslice_pkg::fp_op_e  op_i,
  input  fpslice_pkg::fp_fmt_e fmt_i,
  input  logic                 vector_i,
  input  fpslice_pkg::tag_t    tag_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  logic                 flush_i,
  // Response
  output logic [31:0]          result_o,
  output fpslice_pkg::status_t status_o,
  output fpslice_pkg::tag_t    tag_o,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic                 busy_o
);

  import fpslice_pkg::*;

  logic                 vector_op;
  logic                 result_is_vector;
  fp_fmt_e              result_fmt;
  logic [NUM_LANES-1:0] lane_in_ready;
  logic [NUM_LANES-1:0] lane_out_valid;
  logic [NUM_LANES-1:0] lane_busy;
  lane_rsp_t            lane_rsp    [NUM_LANES];
  status_t              lane_status [NUM_LANES];
  logic [15:0]          lane_half   [NUM_LANES];

  // ----------------------------------------
  // Input side
  // ----------------------------------------
  // Vector mode only makes sense for packed FP16
  assign vector_op  = EnableVectors && vector_i && (fmt_i == FP16);
  assign in_ready_o = lane_in_ready[0];

  // Output metadata always follows lane 0
  assign result_is_vector = lane_rsp[0].vector;
  assign result_fmt       = lane_rsp[0].fmt;

  // ----------------------------------------
  // Lanes
  // ----------------------------------------
  for (genvar lane = 0; lane < NUM_LANES; lane++) begin : gen_lanes
    if ((lane == 0) || EnableVectors) begin : active_lane
      lane_req_t req;
      logic      in_valid;
      logic      out_valid;
      logic      out_ready;

      // Lane 0 keeps the whole word so FP32 works, upper lanes get their half
      assign req.op_a   = op_a_i >> (16 * lane);
      assign req.op_b   = op_b_i >> (16 * lane);
      assign req.op     = op_i;
      assign req.fmt    = fmt_i;
      assign req.vector = vector_op;
      assign req.tag    = tag_i;

      assign in_valid = in_valid_i & ((lane == 0) | vector_op);

      fp_minmax_lane #(
        .NumPipeRegs ( NumPipeRegs )
      ) u_fp_minmax_lane (
        .clk_i       ( clk_i               ),
        .arst_n_i    ( arst_n_i            ),
        .req_i       ( req                 ),
        .in_valid_i  ( in_valid            ),
        .in_ready_o  ( lane_in_ready[lane] ),
        .rsp_o       ( lane_rsp[lane]      ),
        .out_valid_o ( out_valid           ),
        .out_ready_i ( out_ready           ),
        .flush_i     ( flush_i             ),
        .busy_o      ( lane_busy[lane]     )
      );

      // Upper lanes only handshake for vector results
      assign out_ready            = out_ready_i & ((lane == 0) | result_is_vector);
      assign lane_out_valid[lane] = out_valid & ((lane == 0) | result_is_vector);
      assign lane_status[lane]    = lane_out_valid[lane] ? lane_rsp[lane].status : '0;

      if (lane > 0) begin : gen_align_checks
        // Equal depth and shared ready keep the upper lane in step with lane 0
        a_lane_accept : assert property (@(posedge clk_i) disable iff (!arst_n_i)
          (in_valid && in_ready_o) |-> lane_in_ready[lane]);
        a_lane_present : assert property (@(posedge clk_i) disable iff (!arst_n_i)
          (lane_out_valid[0] && result_is_vector) |->
            (out_valid && (lane_rsp[lane].tag == lane_rsp[0].tag)));
      end
    end else begin : inactive_lane
      assign lane_in_ready[lane]  = 1'b0;
      assign lane_out_valid[lane] = 1'b0;
      assign lane_busy[lane]      = 1'b0;
      assign lane_rsp[lane]       = '0;
      assign lane_status[lane]    = '0;
    end

    // Unused upper halves carry the NaN-box
    assign lane_half[lane] = ((lane == 0) || result_is_vector) ?
                             lane_rsp[lane].result[15:0] : 16'hffff;
  end

  // ----------------------------------------
  // Output side
  // ----------------------------------------
  always_comb begin : pack_result
    if (result_fmt == FP32) begin
      result_o = lane_rsp[0].result;
    end else begin
      for (int i = 0; i < NUM_LANES; i++) begin
        result_o[16*i +: 16] = lane_half[i];
      end
    end
  end

  always_comb begin : collapse_status
    status_t acc;
    acc = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      acc |= lane_status[i];
    end
    status_o = acc;
  end

  assign tag_o       = lane_rsp[0].tag;
  assign out_valid_o = lane_out_valid[0];
  assign busy_o      = |lane_busy;

endmodule

/* verif/slice_checker.sv */
// Expects results in acceptance order; a flush drops every entry still pending
`timescale 1ns/1ps

module slice_checker (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  // Input handshake with the expected response alongside
  input  logic                 in_valid_i,
  input  logic                 in_ready_i,
  input  fpslice_pkg::tag_t    in_tag_i,
  input  logic [31:0]          exp_result_i,
  input  fpslice_pkg::status_t exp_status_i,
  input  logic                 flush_i,
  // DUT response
  input  logic                 out_valid_i,
  input  logic                 out_ready_i,
  input  logic [31:0]          result_i,
  input  fpslice_pkg::status_t status_i,
  input  fpslice_pkg::tag_t    tag_i,
  // Counters
  output int                   checked_o,
  output int                   errors_o,
  output int                   pending_o
);

  import fpslice_pkg::*;

  typedef struct packed {
    logic [31:0] result;
    status_t     status;
    tag_t        tag;
  } expect_t;

  expect_t expected_q[$];
  int      checked = 0;
  int      errors  = 0;
  int      pending = 0;

  assign checked_o = checked;
  assign errors_o  = errors;
  assign pending_o = pending;

  always @(posedge clk_i) begin : compare
    expect_t exp;
    if (arst_n_i) begin
      // Output side first, so an item leaving on a flush edge is still checked
      if (out_valid_i && out_ready_i) begin
        if (expected_q.size() == 0) begin
          $display("Unexpected output at %0t: tag_o %h arrived with no operation pending",
                   $time, tag_i);
          errors++;
        end else begin
          exp = expected_q.pop_front();
          checked++;
          if (tag_i !== exp.tag) begin
            $display("Fail at %0t: tag_o = %h, expected %h", $time, tag_i, exp.tag);
            errors++;
          end
          if (result_i !== exp.result) begin
            $display("Fail at %0t: result_o = %h, expected %h (tag %h)",
                     $time, result_i, exp.result, exp.tag);
            errors++;
          end
          if (status_i !== exp.status) begin
            $display("Fail at %0t: status_o = %b, expected %b (tag %h)",
                     $time, status_i, exp.status, exp.tag);
            errors++;
          end
        end
      end
      if (in_valid_i && in_ready_i) begin
        expected_q.push_back({exp_result_i, exp_status_i, in_tag_i});
      end
      if (flush_i) begin
        expected_q.delete();
      end
    end else begin
      expected_q.delete();
    end
    pending = expected_q.size();
  end

endmodule

/* verif/tb_fp_minmax_slice.sv */
// Run from the project root so verif/slice_patterns.txt is found; default depth, vectors on
`timescale 1ns/1ps

module tb_fp_minmax_slice;

  import fpslice_pkg::*;

  localparam int unsigned NumPipeRegs = NUM_PIPE_REGS_DEFAULT;
  localparam int          WaitLimit   = 200;

  typedef struct packed {
    fp_op_e      op;
    fp_fmt_e     fmt;
    logic        vector;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] result;
    status_t     status;
  } pattern_t;

  logic        clk = 1'b0;
  logic        arst_n;
  logic [31:0] op_a;
  logic [31:0] op_b;
  fp_op_e      op;
  fp_fmt_e     fmt;
  logic        vector;
  tag_t        tag;
  logic        in_valid;
  logic        in_ready;
  logic        flush;
  logic [31:0] result;
  status_t     status;
  tag_t        out_tag;
  logic        out_valid;
  logic        out_ready = 1'b1;
  logic        busy;
  logic [31:0] exp_result;
  status_t     exp_status;
  int          checked_cnt;
  int          error_cnt;
  int          pending_cnt;

  pattern_t    patterns[$];
  tag_t        next_tag   = '0;
  logic [1:0]  bp_mode    = 2'd0;
  logic [31:0] lfsr_state = 32'hc40762be;
  logic        aborted    = 1'b0;
  int          tb_errors  = 0;
  int          test_count = 0;

  always #5 clk = ~clk;

  fp_minmax_slice #(
    .NumPipeRegs   ( NumPipeRegs ),
    .EnableVectors ( 1'b1        )
  ) u_fp_minmax_slice (
    .clk_i       ( clk       ),
    .arst_n_i    ( arst_n    ),
    .op_a_i      ( op_a      ),
    .op_b_i      ( op_b      ),
    .op_i        ( op        ),
    .fmt_i       ( fmt       ),
    .vector_i    ( vector    ),
    .tag_i       ( tag       ),
    .in_valid_i  ( in_valid  ),
    .in_ready_o  ( in_ready  ),
    .flush_i     ( flush     ),
    .result_o    ( result    ),
    .status_o    ( status    ),
    .tag_o       ( out_tag   ),
    .out_valid_o ( out_valid ),
    .out_ready_i ( out_ready ),
    .busy_o      ( busy      )
  );

  slice_checker u_slice_checker (
    .clk_i        ( clk         ),
    .arst_n_i     ( arst_n      ),
    .in_valid_i   ( in_valid    ),
    .in_ready_i   ( in_ready    ),
    .in_tag_i     ( tag         ),
    .exp_result_i ( exp_result  ),
    .exp_status_i ( exp_status  ),
    .flush_i      ( flush       ),
    .out_valid_i  ( out_valid   ),
    .out_ready_i  ( out_ready   ),
    .result_i     ( result      ),
    .status_i     ( status      ),
    .tag_i        ( out_tag     ),
    .checked_o    ( checked_cnt ),
    .errors_o     ( error_cnt   ),
    .pending_o    ( pending_cnt )
  );

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  // ----------------------------------------
  // Output ready is always high, random or held low
  // ----------------------------------------
  always @(negedge clk) begin : drive_ready
    logic bit_a;
    logic bit_b;
    if (bp_mode == 2'd1) begin
      lfsr_state = lfsr_next(lfsr_state);
      bit_a      = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
      bit_b      = lfsr_state[0];
      // Low on about one cycle in four
      out_ready  = bit_a | bit_b;
    end else begin
      out_ready = (bp_mode == 2'd0);
    end
  end

  task automatic load_patterns();
    int          fd;
    int          count;
    int          op_v;
    int          fmt_v;
    int          vec_v;
    logic [31:0] a_v;
    logic [31:0] b_v;
    logic [31:0] res_v;
    logic [7:0]  st_v;
    string       line;
    pattern_t    pat;
    fd = $fopen("verif/slice_patterns.txt", "r");
    if (fd == 0) begin
      $display("Cannot open verif/slice_patterns.txt");
      aborted = 1'b1;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        // Comment and blank lines do not scan as seven fields
        count = $sscanf(line, "%d %d %d %h %h %h %h", op_v, fmt_v, vec_v, a_v, b_v, res_v, st_v);
        if (count == 7) begin
          pat.op     = fp_op_e'(op_v[0]);
          pat.fmt    = fp_fmt_e'(fmt_v[0]);
          pat.vector = vec_v[0];
          pat.op_a   = a_v;
          pat.op_b   = b_v;
          pat.result = res_v;
          pat.status = status_t'(st_v[4:0]);
          patterns.push_back(pat);
        end
      end
      $fclose(fd);
    end
  endtask

  // Drives one operation and holds it until the DUT takes it
  task automatic send_op(input pattern_t pat);
    int   cycles;
    logic accepted;
    if (!aborted) begin
      @(negedge clk);
      op_a       = pat.op_a;
      op_b       = pat.op_b;
      op         = pat.op;
      fmt        = pat.fmt;
      vector     = pat.vector;
      tag        = next_tag;
      exp_result = pat.result;
      exp_status = pat.status;
      in_valid   = 1'b1;
      cycles     = 0;
      accepted   = 1'b0;
      while (!accepted && cycles < WaitLimit) begin
        @(posedge clk);
        accepted = in_ready;
        cycles++;
      end
      if (!accepted) begin
        $display("Timeout: in_ready_o stayed low for %0d cycles", WaitLimit);
        aborted = 1'b1;
      end
      next_tag++;
    end
  endtask

  task automatic wait_drain();
    int   cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < WaitLimit) begin
      @(negedge clk);
      done = (pending_cnt == 0) && !busy;
      cycles++;
    end
    if (!done) begin
      $display("Timeout: %0d results still outstanding after %0d cycles", pending_cnt, WaitLimit);
      aborted = 1'b1;
    end
  endtask

  task automatic report_test(input string name, input int errors_before, input int checked_before);
    int new_errors;
    new_errors = error_cnt + tb_errors - errors_before;
    test_count++;
    $display("Test %s: %0d results checked, %0d errors", name, checked_cnt - checked_before,
             new_errors);
  endtask

  task automatic run_patterns(input string name, input logic [1:0] mode);
    int errors_before;
    int checked_before;
    errors_before  = error_cnt + tb_errors;
    checked_before = checked_cnt;
    @(posedge clk);
    bp_mode = mode;
    foreach (patterns[i]) begin
      send_op(patterns[i]);
    end
    @(negedge clk);
    in_valid = 1'b0;
    if (!aborted) begin
      wait_drain();
    end
    report_test(name, errors_before, checked_before);
  endtask

  // ----------------------------------------
  // Flush with a full pipeline
  // ----------------------------------------
  task automatic run_flush();
    int errors_before;
    int checked_before;
    int cycles;
    errors_before  = error_cnt + tb_errors;
    checked_before = checked_cnt;
    @(posedge clk);
    bp_mode = 2'd2;
    // Vector operations fill both lanes
    for (int i = 0; i < int'(NumPipeRegs) && i < patterns.size(); i++) begin
      send_op(patterns[patterns.size() - 1 - i]);
    end
    @(negedge clk);
    in_valid = 1'b0;
    if (NumPipeRegs > 0 && !busy) begin
      $display("Flush: busy_o low with items in flight before flush_i");
      tb_errors++;
    end
    flush    = 1'b1;
    @(negedge clk);
    flush  = 1'b0;
    cycles = 1;
    while (busy && cycles <= int'(NumPipeRegs)) begin
      @(negedge clk);
      cycles++;
    end
    if (busy) begin
      $display("Flush: busy_o still high %0d cycles after flush_i", cycles);
      tb_errors++;
    end
    // Any output now is a flushed item leaking out
    @(posedge clk);
    bp_mode = 2'd0;
    repeat (NumPipeRegs + 2) @(posedge clk);
    for (int i = 0; i < 4 && i < patterns.size(); i++) begin
      send_op(patterns[patterns.size() - 1 - i]);
    end
    @(negedge clk);
    in_valid = 1'b0;
    if (!aborted) begin
      wait_drain();
    end
    report_test("flush", errors_before, checked_before);
  endtask

  initial begin : main
    int total_errors;
    arst_n     = 1'b0;
    op_a       = '0;
    op_b       = '0;
    op         = OP_MIN;
    fmt        = FP32;
    vector     = 1'b0;
    tag        = '0;
    in_valid   = 1'b0;
    flush      = 1'b0;
    exp_result = '0;
    exp_status = '0;
    load_patterns();
    repeat (10) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    if (!aborted && patterns.size() == 0) begin
      $display("No patterns found in verif/slice_patterns.txt");
      aborted = 1'b1;
    end
    if (!aborted) begin
      run_patterns("patterns_full_rate", 2'd0);
    end
    if (!aborted) begin
      run_patterns("patterns_back_pressure", 2'd1);
    end
    if (!aborted) begin
      run_flush();
    end
    total_errors = error_cnt + tb_errors;
    $display("Summary: %0d tests, %0d results checked, %0d errors", test_count, checked_cnt,
             total_errors);
    if (aborted || total_errors != 0) begin
      $display("Regression failed");
    end else begin
      $display("Regression passed");
    end
    $finish;
  end

endmodule

/* src.f */
src/fpslice_pkg.sv
src/fp_pipe_regs.sv
src/fp_minmax_lane.sv
src/fp_minmax_slice.sv
verif/slice_checker.sv
verif/tb_fp_minmax_slice.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_fp_minmax_slice
FILELIST  := src.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Regression passed

SIM       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/slice_patterns.txt */
# op fmt vec op_a op_b result status
# op 0=min 1=max, fmt 0=fp32 1=fp16, vec 1=two fp16 lanes, status in hex (nv dz of uf nx)
# FP32 ordinary numbers and signed zeros
0 0 0 3f800000 40000000 3f800000 00
1 0 0 3f800000 40000000 40000000 00
0 0 0 bf800000 3f800000 bf800000 00
1 0 0 c0400000 bf800000 bf800000 00
0 0 0 80000000 00000000 80000000 00
1 0 0 80000000 00000000 00000000 00
0 0 0 00000000 80000000 80000000 00
0 0 0 7f800000 42c80000 42c80000 00
1 0 0 ff800000 c2c80000 c2c80000 00
# FP32 NaN handling
0 0 0 7fc00000 3f800000 3f800000 00
1 0 0 40490fdb 7fc12345 40490fdb 00
0 0 0 7fc00001 ffc00000 7fc00000 00
1 0 0 7f800001 3f800000 3f800000 10
0 0 0 7fa00000 7fc00000 7fc00000 10
# Scalar FP16 with junk in the upper operand bits
0 1 0 12343c00 abcd4000 ffff3c00 00
1 1 0 deadbc00 beef3c00 ffff3c00 00
0 1 0 00008000 00000000 ffff8000 00
1 1 0 ffff8000 12340000 ffff0000 00
0 1 0 00007e00 0000c500 ffffc500 00
1 1 0 00007c01 00004200 ffff4200 10
0 1 0 0000fe00 00007d00 ffff7e00 10
# Vector FP16, upper half first in each word
0 1 1 4000bc00 3c003c00 3c00bc00 00
1 1 1 c5004600 45004500 45004600 00
1 1 1 7e008000 3c000000 3c000000 00
0 1 1 7c013c00 40004000 40003c00 10
0 1 1 3c007d00 bc007e00 bc007e00 10
1 1 1 7e007e00 ffff4400 7e004400 00
